// File: verilog/ooo_pkg.sv
`default_nettype none

package ooo_pkg;

  // operand and result width
  localparam int data_width = 32;

  // physical register tag, sits in the low bits of a waiting operand
  localparam int preg_width = 8;

  // wrapping dispatch tag, limits the queue to eight entries
  localparam int age_width = 4;

  localparam int iq_depth_default = 8;

  typedef enum logic [2:0] {
    alu_add = 3'd0,
    alu_sub = 3'd1,
    alu_and = 3'd2,
    alu_or  = 3'd3,
    alu_xor = 3'd4,
    alu_sll = 3'd5,
    alu_srl = 3'd6,
    alu_slt = 3'd7
  } alu_cmd_t;

endpackage

`default_nettype wire

// File: verilog/dispatch_port.sv
`default_nettype none

module dispatch_port
  import ooo_pkg::*;
(
  input  wire                         clk,
  input  wire                         rst,
  input  wire                         req,
  output logic                        ack,
  input  alu_cmd_t                    cmd,
  input  wire logic [data_width-1:0]  op1,
  input  wire logic [data_width-1:0]  op2,
  input  wire                         op1_ready,
  input  wire                         op2_ready,
  input  wire logic [preg_width-1:0]  dest,
  input  wire                         full,
  output logic                        wr_en,
  output alu_cmd_t                    wr_cmd,
  output logic [data_width-1:0]       wr_op1,
  output logic [data_width-1:0]       wr_op2,
  output logic                        wr_op1_ready,
  output logic                        wr_op2_ready,
  output logic [preg_width-1:0]       wr_dest
);

  typedef enum logic [1:0] {
    st_idle,
    st_wait_slot,
    st_acked
  } state_t;

  state_t state;

  // fields are held stable by the source for the whole handshake
  assign wr_cmd       = cmd;
  assign wr_op1       = op1;
  assign wr_op2       = op2;
  assign wr_op1_ready = op1_ready;
  assign wr_op2_ready = op2_ready;
  assign wr_dest      = dest;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_idle;
      wr_en <= 1'b0;
      ack   <= 1'b0;
    end else begin
      wr_en <= 1'b0;
      case (state)
        st_idle: begin
          if (req) begin
            if (full) begin
              state <= st_wait_slot;
            end else begin
              wr_en <= 1'b1;
              state <= st_acked;
            end
          end
        end
        st_wait_slot: begin
          // hold off until an issue frees an entry
          if (!full) begin
            wr_en <= 1'b1;
            state <= st_acked;
          end
        end
        st_acked: begin
          if (wr_en) begin
            ack <= 1'b1;
          end else if (!req) begin
            ack   <= 1'b0;
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: verilog/issue_queue.sv
`default_nettype none

module issue_queue
  import ooo_pkg::*;
#(
  parameter int iq_depth = iq_depth_default
) (
  input  wire                         clk,
  input  wire                         rst,
  input  wire                         wr_en,
  input  alu_cmd_t                    wr_cmd,
  input  wire logic [data_width-1:0]  wr_op1,
  input  wire logic [data_width-1:0]  wr_op2,
  input  wire                         wr_op1_ready,
  input  wire                         wr_op2_ready,
  input  wire logic [preg_width-1:0]  wr_dest,
  output logic                        full,
  input  wire                         wb0_valid,
  input  wire logic [preg_width-1:0]  wb0_preg,
  input  wire logic [data_width-1:0]  wb0_data,
  input  wire                         wb1_valid,
  input  wire logic [preg_width-1:0]  wb1_preg,
  input  wire logic [data_width-1:0]  wb1_data,
  output logic                        issue_valid,
  output alu_cmd_t                    issue_cmd,
  output logic [data_width-1:0]       issue_op1,
  output logic [data_width-1:0]       issue_op2,
  output logic [preg_width-1:0]       issue_dest
);

  localparam int idx_width = (iq_depth > 1) ? $clog2(iq_depth) : 1;
  localparam int node_cnt  = 2 * iq_depth - 1;

  // entry state
  logic                  ent_valid [iq_depth];
  logic [age_width-1:0]  ent_age   [iq_depth];
  alu_cmd_t              ent_cmd   [iq_depth];
  logic [data_width-1:0] ent_op1   [iq_depth];
  logic [data_width-1:0] ent_op2   [iq_depth];
  logic                  ent_rdy1  [iq_depth];
  logic                  ent_rdy2  [iq_depth];
  logic [preg_width-1:0] ent_dest  [iq_depth];

  logic [age_width-1:0]  age_ctr;

  // heap-ordered trees, node n has children 2n+1 and 2n+2
  logic                  free_node [node_cnt];
  logic [idx_width-1:0]  free_idx  [node_cnt];
  logic                  sel_node  [node_cnt];
  logic [age_width-1:0]  sel_age   [node_cnt];
  logic [idx_width-1:0]  sel_idx   [node_cnt];

  logic [idx_width-1:0]  wr_slot;
  logic [idx_width-1:0]  iss_slot;

  // a is older than b; a smaller age is younger once the top bits differ
  function automatic logic is_older(input logic [age_width-1:0] a,
                                    input logic [age_width-1:0] b);
    if (a[age_width-1] == b[age_width-1]) begin
      return a < b;
    end
    return a > b;
  endfunction

  // resolve one operand against both result buses, returns {ready, data}
  function automatic logic [data_width:0] wake_op(input logic rdy,
                                                  input logic [data_width-1:0] data);
    if (rdy) begin
      return {1'b1, data};
    end
    if (wb0_valid && wb0_preg == data[preg_width-1:0]) begin
      return {1'b1, wb0_data};
    end
    if (wb1_valid && wb1_preg == data[preg_width-1:0]) begin
      return {1'b1, wb1_data};
    end
    return {1'b0, data};
  endfunction

  always_comb begin
    for (int i = 0; i < iq_depth; i++) begin
      free_node[iq_depth - 1 + i] = !ent_valid[i];
      free_idx[iq_depth - 1 + i]  = idx_width'(i);
      sel_node[iq_depth - 1 + i]  = ent_valid[i] && ent_rdy1[i] && ent_rdy2[i];
      sel_age[iq_depth - 1 + i]   = ent_age[i];
      sel_idx[iq_depth - 1 + i]   = idx_width'(i);
    end
    for (int n = iq_depth - 2; n >= 0; n--) begin
      // lowest free index wins
      free_node[n] = free_node[2*n + 1] || free_node[2*n + 2];
      free_idx[n]  = free_node[2*n + 1] ? free_idx[2*n + 1] : free_idx[2*n + 2];

      // oldest ready entry wins
      sel_node[n] = sel_node[2*n + 1] || sel_node[2*n + 2];
      if (sel_node[2*n + 1] &&
          (!sel_node[2*n + 2] || is_older(sel_age[2*n + 1], sel_age[2*n + 2]))) begin
        sel_age[n] = sel_age[2*n + 1];
        sel_idx[n] = sel_idx[2*n + 1];
      end else begin
        sel_age[n] = sel_age[2*n + 2];
        sel_idx[n] = sel_idx[2*n + 2];
      end
    end
  end

  assign full     = !free_node[0];
  assign wr_slot  = free_idx[0];
  assign iss_slot = sel_idx[0];

  assign issue_valid = sel_node[0];
  assign issue_cmd   = ent_cmd[iss_slot];
  assign issue_op1   = ent_op1[iss_slot];
  assign issue_op2   = ent_op2[iss_slot];
  assign issue_dest  = ent_dest[iss_slot];

  // control state
  always_ff @(posedge clk) begin
    if (rst) begin
      age_ctr <= '0;
      for (int i = 0; i < iq_depth; i++) begin
        ent_valid[i] <= 1'b0;
      end
    end else begin
      if (issue_valid) begin
        ent_valid[iss_slot] <= 1'b0;
      end
      // the free slot is never the issued one
      if (wr_en) begin
        ent_valid[wr_slot] <= 1'b1;
        age_ctr            <= age_ctr + 1'b1;
      end
    end
  end

  // payload and operand readiness
  always_ff @(posedge clk) begin
    for (int i = 0; i < iq_depth; i++) begin
      if (ent_valid[i]) begin
        {ent_rdy1[i], ent_op1[i]} <= wake_op(ent_rdy1[i], ent_op1[i]);
        {ent_rdy2[i], ent_op2[i]} <= wake_op(ent_rdy2[i], ent_op2[i]);
      end
    end
    if (wr_en) begin
      ent_age[wr_slot]  <= age_ctr;
      ent_cmd[wr_slot]  <= wr_cmd;
      ent_dest[wr_slot] <= wr_dest;
      // dispatch bypass, a result on this edge is not missed
      {ent_rdy1[wr_slot], ent_op1[wr_slot]} <= wake_op(wr_op1_ready, wr_op1);
      {ent_rdy2[wr_slot], ent_op2[wr_slot]} <= wake_op(wr_op2_ready, wr_op2);
    end
  end

endmodule

`default_nettype wire

// File: verilog/alu_unit.sv
`default_nettype none

module alu_unit
  import ooo_pkg::*;
(
  input  wire                         clk,
  input  wire                         rst,
  input  wire                         issue_valid,
  input  alu_cmd_t                    issue_cmd,
  input  wire logic [data_width-1:0]  issue_op1,
  input  wire logic [data_width-1:0]  issue_op2,
  input  wire logic [preg_width-1:0]  issue_dest,
  output logic                        res_valid,
  output logic [preg_width-1:0]       res_preg,
  output logic [data_width-1:0]       res_data
);

  logic [data_width-1:0] result;
  logic [4:0]            shamt;

  assign shamt = issue_op2[4:0];

  always_comb begin
    case (issue_cmd)
      alu_add: result = issue_op1 + issue_op2;
      alu_sub: result = issue_op1 - issue_op2;
      alu_and: result = issue_op1 & issue_op2;
      alu_or:  result = issue_op1 | issue_op2;
      alu_xor: result = issue_op1 ^ issue_op2;
      alu_sll: result = issue_op1 << shamt;
      alu_srl: result = issue_op1 >> shamt;
      // signed compare, 0 or 1
      alu_slt: result = data_width'($signed(issue_op1) < $signed(issue_op2));
      default: result = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      res_valid <= 1'b0;
    end else begin
      res_valid <= issue_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (issue_valid) begin
      res_preg <= issue_dest;
      res_data <= result;
    end
  end

endmodule

`default_nettype wire

// File: verilog/exec_core.sv
`default_nettype none

module exec_core
  import ooo_pkg::*;
#(
  parameter int iq_depth = iq_depth_default
) (
  input  wire                         clk,
  input  wire                         rst,
  input  wire                         req,
  output logic                        ack,
  input  alu_cmd_t                    cmd,
  input  wire logic [data_width-1:0]  op1,
  input  wire logic [data_width-1:0]  op2,
  input  wire                         op1_ready,
  input  wire                         op2_ready,
  input  wire logic [preg_width-1:0]  dest,
  input  wire                         ld_valid,
  input  wire logic [preg_width-1:0]  ld_preg,
  input  wire logic [data_width-1:0]  ld_data,
  output logic                        res_valid,
  output logic [preg_width-1:0]       res_preg,
  output logic [data_width-1:0]       res_data
);

  // dispatch to queue
  logic                  wr_en;
  alu_cmd_t              wr_cmd;
  logic [data_width-1:0] wr_op1;
  logic [data_width-1:0] wr_op2;
  logic                  wr_op1_ready;
  logic                  wr_op2_ready;
  logic [preg_width-1:0] wr_dest;
  logic                  full;

  // queue to alu
  logic                  issue_valid;
  alu_cmd_t              issue_cmd;
  logic [data_width-1:0] issue_op1;
  logic [data_width-1:0] issue_op2;
  logic [preg_width-1:0] issue_dest;

  dispatch_port u_dispatch (
    .clk          (clk),
    .rst          (rst),
    .req          (req),
    .ack          (ack),
    .cmd          (cmd),
    .op1          (op1),
    .op2          (op2),
    .op1_ready    (op1_ready),
    .op2_ready    (op2_ready),
    .dest         (dest),
    .full         (full),
    .wr_en        (wr_en),
    .wr_cmd       (wr_cmd),
    .wr_op1       (wr_op1),
    .wr_op2       (wr_op2),
    .wr_op1_ready (wr_op1_ready),
    .wr_op2_ready (wr_op2_ready),
    .wr_dest      (wr_dest)
  );

  // alu result is wakeup port 0, load writeback is port 1
  issue_queue #(
    .iq_depth (iq_depth)
  ) u_issue_queue (
    .clk          (clk),
    .rst          (rst),
    .wr_en        (wr_en),
    .wr_cmd       (wr_cmd),
    .wr_op1       (wr_op1),
    .wr_op2       (wr_op2),
    .wr_op1_ready (wr_op1_ready),
    .wr_op2_ready (wr_op2_ready),
    .wr_dest      (wr_dest),
    .full         (full),
    .wb0_valid    (res_valid),
    .wb0_preg     (res_preg),
    .wb0_data     (res_data),
    .wb1_valid    (ld_valid),
    .wb1_preg     (ld_preg),
    .wb1_data     (ld_data),
    .issue_valid  (issue_valid),
    .issue_cmd    (issue_cmd),
    .issue_op1    (issue_op1),
    .issue_op2    (issue_op2),
    .issue_dest   (issue_dest)
  );

  alu_unit u_alu (
    .clk         (clk),
    .rst         (rst),
    .issue_valid (issue_valid),
    .issue_cmd   (issue_cmd),
    .issue_op1   (issue_op1),
    .issue_op2   (issue_op2),
    .issue_dest  (issue_dest),
    .res_valid   (res_valid),
    .res_preg    (res_preg),
    .res_data    (res_data)
  );

endmodule

`default_nettype wire

// File: tests/tb_clock.sv
`default_nettype none

module tb_clock #(
  parameter int period = 20
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

endmodule

`default_nettype wire

// File: tests/exec_core_sva.sv
`default_nettype none

module exec_core_sva (
  input wire clk,
  input wire rst,
  input wire req,
  input wire ack,
  input wire wr_en,
  input wire full,
  input wire issue_valid,
  input wire res_valid
);

  // read by the testbench for its closing count
  int unsigned fail_count = 0;

  // four-phase rule, ack only answers a held req
  ack_needs_req: assert property (@(posedge clk) disable iff (rst) $rose(ack) |-> req)
    else begin
      fail_count++;
      $error("ack rose while req was low");
    end

  no_write_when_full: assert property (@(posedge clk) disable iff (rst) !(wr_en && full))
    else begin
      fail_count++;
      $error("queue write while the queue was full");
    end

  // one-cycle alu
  result_after_issue: assert property (@(posedge clk) disable iff (rst)
    issue_valid |=> res_valid)
    else begin
      fail_count++;
      $error("issue without a result one cycle later");
    end

  no_result_without_issue: assert property (@(posedge clk) disable iff (rst)
    !issue_valid |=> !res_valid)
    else begin
      fail_count++;
      $error("result without an issue one cycle earlier");
    end

endmodule

`default_nettype wire

// File: tests/exec_core_tb.sv
`default_nettype none

module exec_core_tb
  import ooo_pkg::*;
();

  localparam int chain_len    = 8;
  localparam int fill_count   = 9;
  localparam int random_count = 200;
  localparam int batch_size   = 8;
  localparam int n_dispatch   = 8 + chain_len + fill_count + 1 + random_count;
  localparam int cycle_limit  = 20 * n_dispatch + 200;
  // req edge, then wr_en, write and result edges
  localparam int result_lag   = 4;
  localparam logic [preg_width-1:0] alu_tag_last = 8'hbf;
  localparam logic [preg_width-1:0] ld_tag_first = 8'hc0;

  logic                  clk;
  logic                  rst;
  logic                  req;
  logic                  ack;
  alu_cmd_t              cmd;
  logic [data_width-1:0] op1;
  logic [data_width-1:0] op2;
  logic                  op1_ready;
  logic                  op2_ready;
  logic [preg_width-1:0] dest;
  logic                  ld_valid;
  logic [preg_width-1:0] ld_preg;
  logic [data_width-1:0] ld_data;
  logic                  res_valid;
  logic [preg_width-1:0] res_preg;
  logic [data_width-1:0] res_data;

  // model of the register values, indexed by physical tag
  logic [data_width-1:0] model_val   [256];
  logic                  model_known [256];

  // outstanding instructions, indexed by destination tag
  logic                  pend_valid [256];
  alu_cmd_t              pend_cmd   [256];
  logic [data_width-1:0] pend_a     [256];
  logic [data_width-1:0] pend_b     [256];
  logic                  pend_a_rdy [256];
  logic                  pend_b_rdy [256];
  int unsigned           pend_cycle [256];

  logic [preg_width-1:0] done_order  [$];
  logic [preg_width-1:0] recent_tags [$];
  logic [preg_width-1:0] batch_ld_tags [2];

  int unsigned           outstanding;
  int unsigned           errors;
  int unsigned           checks;
  int unsigned           cycles = 0;
  string                 test_name;
  logic                  check_lag;
  logic [preg_width-1:0] alu_tag_ctr;
  logic [preg_width-1:0] ld_tag_ctr;

  tb_clock #(.period(20)) clock_gen (.clk(clk));

  exec_core #(
    .iq_depth (8)
  ) UUT (
    .clk       (clk),
    .rst       (rst),
    .req       (req),
    .ack       (ack),
    .cmd       (cmd),
    .op1       (op1),
    .op2       (op2),
    .op1_ready (op1_ready),
    .op2_ready (op2_ready),
    .dest      (dest),
    .ld_valid  (ld_valid),
    .ld_preg   (ld_preg),
    .ld_data   (ld_data),
    .res_valid (res_valid),
    .res_preg  (res_preg),
    .res_data  (res_data)
  );

  bind exec_core exec_core_sva sva_checks (
    .clk         (clk),
    .rst         (rst),
    .req         (req),
    .ack         (ack),
    .wr_en       (wr_en),
    .full        (full),
    .issue_valid (issue_valid),
    .res_valid   (res_valid)
  );

  function automatic logic [data_width-1:0] ref_result(input alu_cmd_t c,
                                                       input logic [data_width-1:0] a,
                                                       input logic [data_width-1:0] b);
    logic [4:0] sh;
    sh = b[4:0];
    case (c)
      alu_add: return a + b;
      alu_sub: return a - b;
      alu_and: return a & b;
      alu_or:  return a | b;
      alu_xor: return a ^ b;
      alu_sll: return a << sh;
      alu_srl: return a >> sh;
      alu_slt: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      default: return '0;
    endcase
  endfunction

  task automatic next_alu_dest(output logic [preg_width-1:0] tag);
    tag = alu_tag_ctr;
    alu_tag_ctr = (alu_tag_ctr == alu_tag_last) ? 8'h01 : alu_tag_ctr + 8'h01;
    model_known[tag] = 1'b0;
  endtask

  task automatic take_load_tag(output logic [preg_width-1:0] tag);
    tag = ld_tag_ctr;
    ld_tag_ctr = (ld_tag_ctr == 8'hff) ? ld_tag_first : ld_tag_ctr + 8'h01;
    model_known[tag] = 1'b0;
  endtask

  // a produced value goes in ready, as rename would hand it over
  task automatic tag_operand(input logic [preg_width-1:0] tag,
                             output logic [data_width-1:0] val,
                             output logic rdy);
    if (model_known[tag]) begin
      val = model_val[tag];
      rdy = 1'b1;
    end else begin
      val = {{(data_width - preg_width){1'b0}}, tag};
      rdy = 1'b0;
    end
  endtask

  task automatic pick_operand(output logic [data_width-1:0] val, output logic rdy);
    int unsigned sel;
    sel = $urandom_range(0, 3);
    if (sel == 2 && recent_tags.size() > 0) begin
      tag_operand(recent_tags[$urandom_range(0, recent_tags.size() - 1)], val, rdy);
    end else if (sel == 3) begin
      tag_operand(batch_ld_tags[$urandom_range(0, 1)], val, rdy);
    end else begin
      val = $urandom();
      rdy = 1'b1;
    end
  endtask

  task automatic send_instr(input alu_cmd_t c,
                            input logic [data_width-1:0] a, input logic a_rdy,
                            input logic [data_width-1:0] b, input logic b_rdy,
                            input logic [preg_width-1:0] d);
    @(posedge clk);
    req       <= 1'b1;
    cmd       <= c;
    op1       <= a;
    op1_ready <= a_rdy;
    op2       <= b;
    op2_ready <= b_rdy;
    dest      <= d;
    pend_valid[d] = 1'b1;
    pend_cmd[d]   = c;
    pend_a[d]     = a;
    pend_a_rdy[d] = a_rdy;
    pend_b[d]     = b;
    pend_b_rdy[d] = b_rdy;
    pend_cycle[d] = cycles;
    outstanding++;
    // fields stay put until ack, then release and wait for ack to drop
    do @(posedge clk); while (!ack);
    req <= 1'b0;
    do @(posedge clk); while (ack);
  endtask

  task automatic deliver_load(input logic [preg_width-1:0] tag,
                              input logic [data_width-1:0] val);
    @(posedge clk);
    ld_valid <= 1'b1;
    ld_preg  <= tag;
    ld_data  <= val;
    model_val[tag]   = val;
    model_known[tag] = 1'b1;
    @(posedge clk);
    ld_valid <= 1'b0;
  endtask

  task automatic drain_queue();
    while (outstanding != 0) begin
      @(posedge clk);
    end
    repeat (2) @(posedge clk);
  endtask

  task automatic check_result();
    logic [preg_width-1:0] tag;
    logic [preg_width-1:0] ta;
    logic [preg_width-1:0] tb;
    logic [data_width-1:0] exp;
    tag = res_preg;
    done_order.push_back(tag);
    assert (pend_valid[tag]) else begin
      errors++;
      $display("%s: result on tag %02h with no outstanding instruction", test_name, tag);
    end
    if (pend_valid[tag]) begin
      ta = pend_a[tag][preg_width-1:0];
      tb = pend_b[tag][preg_width-1:0];
      assert ((pend_a_rdy[tag] || model_known[ta]) && (pend_b_rdy[tag] || model_known[tb]))
        else begin
          errors++;
          $display("%s: tag %02h completed before its source values existed", test_name, tag);
        end
      exp = ref_result(pend_cmd[tag], pend_a_rdy[tag] ? pend_a[tag] : model_val[ta],
                       pend_b_rdy[tag] ? pend_b[tag] : model_val[tb]);
      checks++;
      assert (res_data === exp) else begin
        errors++;
        $display("error %s: tag %02h expected %08h actual %08h", test_name, tag, exp, res_data);
      end
      if (check_lag) begin
        checks++;
        assert (cycles - pend_cycle[tag] == result_lag) else begin
          errors++;
          $display("error %s: tag %02h latency expected %0d actual %0d", test_name, tag,
                   result_lag, cycles - pend_cycle[tag]);
        end
      end
      model_val[tag]   = exp;
      model_known[tag] = 1'b1;
      pend_valid[tag]  = 1'b0;
      outstanding--;
    end
  endtask

  task automatic sweep_commands();
    logic [preg_width-1:0] d;
    test_name = "cmd_sweep";
    check_lag = 1'b1;
    for (int c = 0; c < 8; c++) begin
      next_alu_dest(d);
      send_instr(alu_cmd_t'(c), $urandom(), 1'b1, $urandom(), 1'b1, d);
      drain_queue();
    end
    check_lag = 1'b0;
  endtask

  task automatic dependency_chain();
    logic [preg_width-1:0] ld_tag;
    logic [preg_width-1:0] tags [chain_len];
    logic [data_width-1:0] a;
    logic                  a_rdy;
    test_name = "dep_chain";
    done_order.delete();
    take_load_tag(ld_tag);
    for (int i = 0; i < chain_len; i++) begin
      // head waits on the load, each later one on its predecessor
      if (i == 0) begin
        tag_operand(ld_tag, a, a_rdy);
      end else begin
        tag_operand(tags[i - 1], a, a_rdy);
      end
      next_alu_dest(tags[i]);
      send_instr(alu_cmd_t'($urandom_range(0, 7)), a, a_rdy, $urandom(), 1'b1, tags[i]);
    end
    deliver_load(ld_tag, $urandom());
    drain_queue();
    checks++;
    assert (done_order.size() == chain_len) else begin
      errors++;
      $display("error %s: result count expected %0d actual %0d", test_name, chain_len,
               done_order.size());
    end
    if (done_order.size() == chain_len) begin
      for (int i = 0; i < chain_len; i++) begin
        checks++;
        assert (done_order[i] == tags[i]) else begin
          errors++;
          $display("error %s: position %0d expected tag %02h actual %02h", test_name, i,
                   tags[i], done_order[i]);
        end
      end
    end
  endtask

  task automatic fill_queue();
    logic [preg_width-1:0] ld_tag;
    logic [preg_width-1:0] d;
    logic [data_width-1:0] a;
    logic [data_width-1:0] b;
    logic                  a_rdy;
    alu_cmd_t              c;
    test_name = "queue_full";
    take_load_tag(ld_tag);
    for (int i = 0; i < fill_count - 1; i++) begin
      tag_operand(ld_tag, a, a_rdy);
      next_alu_dest(d);
      send_instr(alu_cmd_t'($urandom_range(0, 7)), a, a_rdy, $urandom(), 1'b1, d);
    end
    next_alu_dest(d);
    c = alu_cmd_t'($urandom_range(0, 7));
    a = $urandom();
    b = $urandom();
    fork
      send_instr(c, a, 1'b1, b, 1'b1, d);
      begin
        repeat (12) begin
          @(posedge clk);
          checks++;
          assert (!ack) else begin
            errors++;
            $display("%s: ack given while the queue was full", test_name);
          end
        end
        deliver_load(ld_tag, $urandom());
      end
    join
    drain_queue();
  endtask

  task automatic load_bypass();
    logic [preg_width-1:0] ld_tag;
    logic [preg_width-1:0] d;
    logic [data_width-1:0] a;
    logic [data_width-1:0] b;
    logic [data_width-1:0] ld_val;
    logic                  a_rdy;
    alu_cmd_t              c;
    test_name = "load_bypass";
    take_load_tag(ld_tag);
    next_alu_dest(d);
    tag_operand(ld_tag, a, a_rdy);
    c = alu_cmd_t'($urandom_range(0, 7));
    b = $urandom();
    ld_val = $urandom();
    fork
      send_instr(c, a, a_rdy, b, 1'b1, d);
      begin
        // load sits on the bus in the wr_en cycle
        @(posedge clk);
        deliver_load(ld_tag, ld_val);
      end
    join
    drain_queue();
  endtask

  task automatic random_mix();
    logic [preg_width-1:0] d;
    logic [data_width-1:0] a;
    logic [data_width-1:0] b;
    logic                  a_rdy;
    logic                  b_rdy;
    test_name = "random_mix";
    for (int batch = 0; batch < random_count / batch_size; batch++) begin
      recent_tags.delete();
      take_load_tag(batch_ld_tags[0]);
      take_load_tag(batch_ld_tags[1]);
      for (int i = 0; i < batch_size; i++) begin
        pick_operand(a, a_rdy);
        pick_operand(b, b_rdy);
        next_alu_dest(d);
        send_instr(alu_cmd_t'($urandom_range(0, 7)), a, a_rdy, b, b_rdy, d);
        recent_tags.push_back(d);
        if (recent_tags.size() > 4) begin
          void'(recent_tags.pop_front());
        end
      end
      // loads come last so every waiting chain resolves after them
      deliver_load(batch_ld_tags[0], $urandom());
      deliver_load(batch_ld_tags[1], $urandom());
      drain_queue();
    end
  endtask

  always @(negedge clk) begin
    if (!rst && res_valid) begin
      check_result();
    end
  end

  // watchdog
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  initial begin
    int unsigned sva_fails;
    void'($urandom(32'h00f2_8bfb));
    rst         = 1'b1;
    req         = 1'b0;
    cmd         = alu_add;
    op1         = '0;
    op2         = '0;
    op1_ready   = 1'b0;
    op2_ready   = 1'b0;
    dest        = '0;
    ld_valid    = 1'b0;
    ld_preg     = '0;
    ld_data     = '0;
    outstanding = 0;
    errors      = 0;
    checks      = 0;
    check_lag   = 1'b0;
    alu_tag_ctr = 8'h01;
    ld_tag_ctr  = ld_tag_first;
    test_name   = "reset";
    for (int i = 0; i < 256; i++) begin
      model_known[i] = 1'b0;
      pend_valid[i]  = 1'b0;
    end
    repeat (5) @(posedge clk);
    rst <= 1'b0;

    sweep_commands();
    dependency_chain();
    fill_queue();
    load_bypass();
    random_mix();

    sva_fails = UUT.sva_checks.fail_count;
    $display("checks %0d, check errors %0d, assertion failures %0d", checks, errors,
             sva_fails);
    if (errors == 0 && sva_fails == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
verilog/ooo_pkg.sv
verilog/dispatch_port.sv
verilog/issue_queue.sv
verilog/alu_unit.sv
verilog/exec_core.sv
tests/tb_clock.sv
tests/exec_core_sva.sv
tests/exec_core_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= exec_core_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing --assert
SIM_FLAGS ?= +verilator+error+limit+100
FAIL_MSG  := RESULT: FAIL
PASS_MSG  := RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) $(SIM_FLAGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi; \
	if ! grep -q "$(PASS_MSG)" $(LOG); then echo "no result line in $(LOG)"; exit 1; fi; \
	exit $$status

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
